// ==== design/lab_pkg.sv ====
package lab_pkg;

    //----------------------------------------------------------
    // Board dimensions

    localparam int w_key   = 4;   // Lab keys, reset is separate
    localparam int w_sw    = 8;   // Two BCD digits for load
    localparam int w_led   = 6;
    localparam int w_digit = 4;   // Display digits
    localparam int w_seg   = 8;   // abcdefgh, a is the MSB

    //----------------------------------------------------------
    // Timing

    localparam int scan_period         = 8;          // Cycles per digit
    localparam int default_tick_period = 27_000_000; // 1 Hz at 27 MHz

    // Derived counter widths
    localparam int w_scan      = $clog2(scan_period);
    localparam int w_digit_idx = $clog2(w_digit);

    //----------------------------------------------------------
    // Command strobes from the key decoder

    typedef struct packed {
        logic                toggle_run;  // Key 0
        logic                clear;       // Key 1
        logic                load;        // Key 2
        logic                toggle_dir;  // Key 3
        logic [w_sw - 1:0]   load_value;  // Valid with load only
    } key_cmd_t;

    //----------------------------------------------------------
    // Four BCD digits, d0 is the least significant

    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } bcd_count_t;

endpackage

// ==== design/slow_clk_gen.sv ====
`timescale 1ns/1ps

module slow_clk_gen
# (
    parameter int tick_period = lab_pkg::default_tick_period
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int w_cnt = $clog2(tick_period);

    logic [w_cnt - 1:0] cnt;

    // Enable pulse instead of a derived clock, one domain only
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt  <= w_cnt'(tick_period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(tick_period - 1);  // Reload
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== design/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [lab_pkg::w_key - 1:0] key,
    input  logic [lab_pkg::w_sw  - 1:0] sw,
    output lab_pkg::key_cmd_t           cmd
);

    logic [lab_pkg::w_key - 1:0] sync1;
    logic [lab_pkg::w_key - 1:0] sync2;
    logic [lab_pkg::w_key - 1:0] prev;
    logic [lab_pkg::w_key - 1:0] rise;

    //----------------------------------------------------------
    // Synchroniser and edge detect

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
            rise  <= '0;
        end
        else
        begin
            sync1 <= key;
            sync2 <= sync1;
            prev  <= sync2;
            rise  <= sync2 & ~prev;   // One cycle per press
        end
    end

    //----------------------------------------------------------
    // Command register

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cmd <= '0;
        end
        else
        begin
            cmd.toggle_run <= rise [0];
            cmd.clear      <= rise [1];
            cmd.load       <= rise [2];
            cmd.toggle_dir <= rise [3];

            // Switches are taken on the load edge only
            cmd.load_value <= rise [2] ? sw : '0;
        end
    end

endmodule

// ==== design/bcd_counter.sv ====
`timescale 1ns/1ps

module bcd_counter
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tick,
    input  lab_pkg::key_cmd_t           cmd,
    output lab_pkg::bcd_count_t         count,
    output logic [lab_pkg::w_led - 1:0] led
);

    logic running;
    logic down;
    logic heartbeat;
    logic step;

    // One BCD step, carry or borrow ripples through all digits
    function automatic lab_pkg::bcd_count_t bcd_step
    (
        input lab_pkg::bcd_count_t c,
        input logic                dn
    );
        logic [lab_pkg::w_digit - 1:0][3:0] d;
        logic                               carry;

        d     = c;
        carry = 1'b1;

        for (int i = 0; i < lab_pkg::w_digit; i++)
        begin
            if (carry)
            begin
                if (dn)
                begin
                    carry = (d [i] == 4'd0);
                    d [i] = carry ? 4'd9 : d [i] - 4'd1;
                end
                else
                begin
                    carry = (d [i] == 4'd9);
                    d [i] = carry ? 4'd0 : d [i] + 4'd1;
                end
            end
        end

        return d;
    endfunction

    function automatic logic [3:0] clamp_bcd (input logic [3:0] n);
        return (n > 4'd9) ? 4'd9 : n;
    endfunction

    //----------------------------------------------------------

    assign step = tick & running;

    // Commands win over tick
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count     <= '0;
            running   <= 1'b0;
            down      <= 1'b0;
            heartbeat <= 1'b0;
        end
        else if (cmd.clear)
            count <= '0;                          // Run flag untouched
        else if (cmd.load)
            count <= {8'h00, clamp_bcd(cmd.load_value [7:4]),
                             clamp_bcd(cmd.load_value [3:0])};
        else if (cmd.toggle_run | cmd.toggle_dir)
        begin
            running <= running ^ cmd.toggle_run;
            down    <= down    ^ cmd.toggle_dir;
        end
        else if (step)
        begin
            count     <= bcd_step(count, down);
            heartbeat <= ~heartbeat;
        end
    end

    assign led = {heartbeat, running, count.d0};

endmodule

// ==== design/seg7_scanner.sv ====
`timescale 1ns/1ps

module seg7_scanner
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  lab_pkg::bcd_count_t           count,
    output logic [lab_pkg::w_seg   - 1:0] abcdefgh,
    output logic [lab_pkg::w_digit - 1:0] digit
);

    logic [lab_pkg::w_scan      - 1:0] scan_cnt;
    logic [lab_pkg::w_digit_idx - 1:0] idx;
    logic [3:0]                        cur;

    // Segment pattern, h stays dark
    function automatic logic [lab_pkg::w_seg - 1:0] seg_of (input logic [3:0] v);
        case (v)
            4'd0:    return 8'b1111_1100;
            4'd1:    return 8'b0110_0000;
            4'd2:    return 8'b1101_1010;
            4'd3:    return 8'b1111_0010;
            4'd4:    return 8'b0110_0110;
            4'd5:    return 8'b1011_0110;
            4'd6:    return 8'b1011_1110;
            4'd7:    return 8'b1110_0000;
            4'd8:    return 8'b1111_1110;
            4'd9:    return 8'b1111_0110;
            default: return 8'b0000_0000;   // Not BCD, blank
        endcase
    endfunction

    //----------------------------------------------------------
    // Slot timer and digit index

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan_cnt <= '0;
            idx      <= '0;
        end
        else if (scan_cnt == lab_pkg::w_scan'(lab_pkg::scan_period - 1))
        begin
            scan_cnt <= '0;
            idx      <= idx + 1'b1;   // d0 .. d3, then back
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_comb
    begin
        case (idx)
            2'd0:    cur = count.d0;
            2'd1:    cur = count.d1;
            2'd2:    cur = count.d2;
            default: cur = count.d3;
        endcase
    end

    //----------------------------------------------------------
    // Output register, segments and strobe move together

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            digit    <= lab_pkg::w_digit'(1);
            abcdefgh <= seg_of(4'd0);
        end
        else
        begin
            digit    <= lab_pkg::w_digit'(1) << idx;
            abcdefgh <= seg_of(cur);
        end
    end

endmodule

// ==== design/lab_top.sv ====
`timescale 1ns/1ps

module lab_top
# (
    parameter int tick_period = lab_pkg::default_tick_period
)
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [lab_pkg::w_key   - 1:0] key,
    input  logic [lab_pkg::w_sw    - 1:0] sw,
    output logic [lab_pkg::w_led   - 1:0] led,
    output logic [lab_pkg::w_seg   - 1:0] abcdefgh,
    output logic [lab_pkg::w_digit - 1:0] digit
);

    logic                tick;
    lab_pkg::key_cmd_t   cmd;
    lab_pkg::bcd_count_t count;

    //----------------------------------------------------------

    slow_clk_gen # (.tick_period (tick_period))
    i_slow_clk_gen (.clk (clk), .rst_n (rst_n), .tick (tick));

    key_decoder i_key_decoder
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sw       ( sw       ),
        .cmd      ( cmd      )
    );

    bcd_counter i_bcd_counter
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .tick     ( tick     ),
        .cmd      ( cmd      ),
        .count    ( count    ),
        .led      ( led      )
    );

    seg7_scanner i_seg7_scanner
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .count    ( count    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== design/board_specific_top.sv ====
`timescale 1ns/1ps

module board_specific_top
# (
    parameter int tick_period = lab_pkg::default_tick_period  // 2 or more
)
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [lab_pkg::w_key   - 1:0] KEY,    // Active low
    input  logic [lab_pkg::w_sw    - 1:0] SW,     // Active low

    output logic [lab_pkg::w_led   - 1:0] LED,    // Active low

    output logic [lab_pkg::w_seg   - 1:0] abcdefgh,
    output logic [lab_pkg::w_digit - 1:0] digit
);

    logic [lab_pkg::w_key - 1:0] lab_key;
    logic [lab_pkg::w_sw  - 1:0] lab_sw;
    logic [lab_pkg::w_led - 1:0] lab_led;

    //----------------------------------------------------------
    // Board polarity, the lab sees active high only

    assign lab_key = ~ KEY;
    assign lab_sw  = ~ SW;
    assign LED     = ~ lab_led;

    //----------------------------------------------------------

    lab_top
    # (
        .tick_period ( tick_period )
    )
    i_lab_top
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),

        .key         ( lab_key     ),
        .sw          ( lab_sw      ),

        .led         ( lab_led     ),

        .abcdefgh    ( abcdefgh    ),   // Display is active high
        .digit       ( digit       )
    );

endmodule

// ==== bench/board_sva.sv ====
`timescale 1ns/1ps

module board_sva
(
    input logic                          clk,
    input logic                          rst_n,
    input logic [lab_pkg::w_seg   - 1:0] abcdefgh,
    input logic [lab_pkg::w_digit - 1:0] digit
);

    logic [lab_pkg::w_digit - 1:0] last_digit;
    logic                          armed;   // First slot after reset runs long
    int                            held;    // Cycles since the last digit change

    always_ff @(posedge clk)
    begin
        last_digit <= digit;
        if (!rst_n)
        begin
            held  <= 0;
            armed <= 1'b0;
        end
        else if (digit != last_digit)
        begin
            held  <= 0;
            armed <= 1'b1;
        end
        else
            held <= held + 1;
    end

    //----------------------------------------------------------

    digit_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit))
        else $error("digit strobe is not one-hot");

    slot_length : assert property (@(posedge clk) disable iff (!rst_n)
        (armed && digit != last_digit) |-> (held == lab_pkg::scan_period - 1))
        else $error("digit strobe moved after %0d cycles", held + 1);

    point_dark : assert property (@(posedge clk) disable iff (!rst_n)
        abcdefgh[0] == 1'b0)
        else $error("decimal point segment lit");

endmodule

bind seg7_scanner board_sva sva0
(
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .abcdefgh ( abcdefgh ),
    .digit    ( digit    )
);

// ==== bench/board_checker.sv ====
`timescale 1ns/1ps

module board_checker
(
    input  logic                          clk,
    input  logic [lab_pkg::w_led   - 1:0] led_n,
    input  logic [lab_pkg::w_seg   - 1:0] abcdefgh,
    input  logic [lab_pkg::w_digit - 1:0] digit,
    input  int                            test_num,
    input  logic                          check_req,
    input  logic                          check_disp,
    input  lab_pkg::bcd_count_t           exp_count,
    input  logic [lab_pkg::w_led   - 1:0] exp_led,
    input  logic [lab_pkg::w_led   - 1:0] led_mask,
    output logic                          check_done,
    output int                            pass_cnt,
    output int                            fail_cnt
);

    // Segments back to a digit, 4'hf for anything that is not 0 to 9
    function automatic logic [3:0] seg_digit (input logic [lab_pkg::w_seg - 1:0] s);
        case (s)
            8'b1111_1100: return 4'd0;
            8'b0110_0000: return 4'd1;
            8'b1101_1010: return 4'd2;
            8'b1111_0010: return 4'd3;
            8'b0110_0110: return 4'd4;
            8'b1011_0110: return 4'd5;
            8'b1011_1110: return 4'd6;
            8'b1110_0000: return 4'd7;
            8'b1111_1110: return 4'd8;
            8'b1111_0110: return 4'd9;
            default:      return 4'hf;
        endcase
    endfunction

    // One full scan, each slot sampled in its middle
    task automatic read_scan (output lab_pkg::bcd_count_t shown, output logic ok);
        logic [3:0] d [lab_pkg::w_digit];
        ok = 1'b1;
        @(negedge clk);
        while (digit == 4'b0001)
            @(negedge clk);
        while (digit != 4'b0001)
            @(negedge clk);                    // First cycle of the d0 slot
        for (int i = 0; i < lab_pkg::w_digit; i++)
        begin
            repeat (lab_pkg::scan_period / 2) @(negedge clk);
            d[i] = seg_digit(abcdefgh);
            if (digit != 4'(1 << i) || d[i] > 4'd9)
                ok = 1'b0;
            if (i < lab_pkg::w_digit - 1)
                repeat (lab_pkg::scan_period / 2) @(negedge clk);
        end
        shown = {d[3], d[2], d[1], d[0]};
    endtask

    //----------------------------------------------------------

    initial
    begin
        lab_pkg::bcd_count_t           shown_a;
        lab_pkg::bcd_count_t           shown_b;
        logic                          ok_a;
        logic                          ok_b;
        logic [lab_pkg::w_led - 1:0]   led_seen;

        check_done = 1'b0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        forever
        begin
            wait (check_req);
            @(negedge clk);
            led_seen = led_n;
            ok_a     = 1'b1;
            ok_b     = 1'b1;
            shown_a  = exp_count;
            shown_b  = exp_count;
            if (check_disp)
            begin
                read_scan(shown_a, ok_a);
                read_scan(shown_b, ok_b);   // Must match the first scan
            end

            if (!(ok_a && ok_b))
            begin
                fail_cnt++;
                $display("Test %0d failed: a digit slot had no valid 0 to 9 pattern or strobe",
                         test_num);
            end
            else if (shown_a != shown_b)
            begin
                fail_cnt++;
                $display("Test %0d failed: the display changed while the counter was stopped",
                         test_num);
            end
            else if (shown_a != exp_count)
            begin
                fail_cnt++;
                $display("Mismatch at %0t: test %0d display %h, expected %h",
                         $time, test_num, shown_a, exp_count);
            end
            else if ((led_seen & led_mask) != (exp_led & led_mask))
            begin
                fail_cnt++;
                $display("Mismatch at %0t: test %0d LED %b, expected %b under mask %b",
                         $time, test_num, led_seen, exp_led, led_mask);
            end
            else
            begin
                pass_cnt++;
                $display("Test %0d passed: display %h LED %b", test_num, shown_a, led_seen);
            end

            check_done = 1'b1;
            wait (!check_req);
            check_done = 1'b0;
        end
    end

endmodule

// ==== bench/tb_board.sv ====
`timescale 1ns/1ps

module tb_board;

    localparam int tick_period = 40;
    localparam int clk_period  = 4;
    localparam int n_rows      = 16;
    localparam int max_hold    = 600;
    localparam int watchdog_ns = n_rows * max_hold * clk_period * 2;

    // Action codes 0 to 3 match the key numbers
    localparam logic [2:0]  act_run   = 3'd0;
    localparam logic [2:0]  act_clear = 3'd1;
    localparam logic [2:0]  act_load  = 3'd2;
    localparam logic [2:0]  act_dir   = 3'd3;
    localparam logic [2:0]  act_idle  = 3'd4;
    localparam logic [15:0] exp_skip  = 16'hffff;   // Running, display moves
    localparam logic [15:0] exp_model = 16'heeee;   // Taken from the tick model

    typedef struct packed {
        logic [2:0]  act;
        logic        rnd;       // Random switch value
        logic [7:0]  sw;
        logic [11:0] hold;      // Cycles after the key is released
        logic [15:0] exp_val;
    } row_t;

    logic                          clk;
    logic                          rst_n;
    logic [lab_pkg::w_key   - 1:0] key_n;
    logic [lab_pkg::w_sw    - 1:0] sw_n;
    logic [lab_pkg::w_led   - 1:0] led_n;
    logic [lab_pkg::w_seg   - 1:0] abcdefgh;
    logic [lab_pkg::w_digit - 1:0] digit;
    logic                          check_req;
    logic                          check_disp;
    logic                          check_done;
    lab_pkg::bcd_count_t           exp_count;
    logic [lab_pkg::w_led   - 1:0] exp_led;
    logic [lab_pkg::w_led   - 1:0] led_mask;
    int                            test_num;
    int                            pass_cnt;
    int                            fail_cnt;
    int                            tick_cnt;
    int                            used_ticks;
    int                            model_val;
    logic                          model_run;
    logic                          model_down;
    logic                          hb_known;       // Heartbeat still at reset value
    logic                          last_hb;
    int                            seed;
    row_t                          rows [n_rows];

    board_specific_top # (.tick_period (tick_period)) dut0
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .KEY      ( key_n    ),
        .SW       ( sw_n     ),
        .LED      ( led_n    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    board_checker chk0
    (
        .clk        ( clk        ),
        .led_n      ( led_n      ),
        .abcdefgh   ( abcdefgh   ),
        .digit      ( digit      ),
        .test_num   ( test_num   ),
        .check_req  ( check_req  ),
        .check_disp ( check_disp ),
        .exp_count  ( exp_count  ),
        .exp_led    ( exp_led    ),
        .led_mask   ( led_mask   ),
        .check_done ( check_done ),
        .pass_cnt   ( pass_cnt   ),
        .fail_cnt   ( fail_cnt   )
    );

    //----------------------------------------------------------
    // Decimal model of the stopwatch

    function automatic int next_count (input int v, input logic dn);
        return dn ? (v + 9999) % 10000 : (v + 1) % 10000;
    endfunction

    function automatic int clamp_digit (input logic [3:0] n);
        return (n > 4'd9) ? 9 : int'(n);
    endfunction

    function automatic lab_pkg::bcd_count_t to_bcd (input int v);
        return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
    endfunction

    // Ticks counted so far go in with the direction they ran in
    task automatic catch_up;
        while (used_ticks < tick_cnt)
        begin
            if (model_run)      // A stopped counter holds its value
                model_val = next_count(model_val, model_down);
            used_ticks++;
        end
    endtask

    task automatic press_key (input int k, input logic [7:0] sw_val);
        @(posedge clk);
        #1;
        sw_n     = ~sw_val;
        key_n[k] = 1'b0;
        repeat (5) @(posedge clk);      // Counter acts on the fifth edge
        @(negedge clk);
        catch_up();
        case (k)
            0:
            begin
                model_run = ~model_run;
                hb_known  = 1'b0;
            end
            1:       model_val = 0;     // Run flag kept
            2:       model_val = clamp_digit(sw_val[7:4]) * 10 + clamp_digit(sw_val[3:0]);
            default: model_down = ~model_down;
        endcase
        @(posedge clk);
        #1;
        key_n[k] = 1'b1;
        repeat (6) @(posedge clk);
    endtask

    task automatic post_check (input row_t r);
        lab_pkg::bcd_count_t expv;
        #1;
        catch_up();
        if (r.exp_val == exp_model)
            expv = to_bcd(model_val);
        else
            expv = lab_pkg::bcd_count_t'(r.exp_val);
        check_disp = (r.exp_val != exp_skip);
        exp_count  = expv;
        exp_led    = ~{1'b0, model_run, expv.d0};
        led_mask   = check_disp ? {hb_known, 5'b11111} : 6'b010000;
        check_req  = 1'b1;
        wait (check_done);
        check_req  = 1'b0;
        wait (!check_done);
    endtask

    //----------------------------------------------------------

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Heartbeat LED edges, one per counted tick
    initial
    begin
        tick_cnt = 0;
        last_hb  = 1'b1;
        forever
        begin
            @(negedge clk);
            if (rst_n && led_n[5] != last_hb)
                tick_cnt++;
            last_hb = led_n[5];
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the test table did not finish within %0d ns", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        logic [7:0] sw_val;

        rows = '{
            '{act_idle,  1'b0, 8'h00, 12'd20,  16'h0000},
            '{act_load,  1'b1, 8'h00, 12'd20,  exp_model},
            '{act_load,  1'b1, 8'h00, 12'd20,  exp_model},
            '{act_load,  1'b0, 8'hbe, 12'd20,  16'h0099},  // Both nibbles clamp
            '{act_load,  1'b0, 8'h95, 12'd20,  16'h0095},
            '{act_run,   1'b0, 8'h00, 12'd600, exp_skip},  // Carry into 0100
            '{act_run,   1'b0, 8'h00, 12'd20,  exp_model},
            '{act_idle,  1'b0, 8'h00, 12'd200, exp_model},  // Held while stopped
            '{act_clear, 1'b0, 8'h00, 12'd20,  16'h0000},
            '{act_load,  1'b0, 8'h03, 12'd20,  16'h0003},
            '{act_run,   1'b0, 8'h00, 12'd100, exp_skip},
            '{act_dir,   1'b0, 8'h00, 12'd400, exp_skip},  // Down through 0000
            '{act_clear, 1'b0, 8'h00, 12'd100, exp_skip},
            '{act_run,   1'b0, 8'h00, 12'd20,  exp_model},
            '{act_dir,   1'b0, 8'h00, 12'd20,  exp_model},
            '{act_clear, 1'b0, 8'h00, 12'd20,  16'h0000}
        };
        seed       = 22661;
        rst_n      = 1'b0;
        key_n      = '1;
        sw_n       = '1;
        check_req  = 1'b0;
        check_disp = 1'b0;
        exp_count  = '0;
        exp_led    = '1;
        led_mask   = '0;
        test_num   = 0;
        used_ticks = 0;
        model_val  = 0;
        model_run  = 1'b0;
        model_down = 1'b0;
        hb_known   = 1'b1;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < n_rows; i++)
        begin
            sw_val   = rows[i].rnd ? 8'($random(seed)) : rows[i].sw;
            test_num = i;
            if (rows[i].act != act_idle)
                press_key(int'(rows[i].act), sw_val);
            repeat (rows[i].hold) @(posedge clk);
            post_check(rows[i]);
        end

        $display("Tests: %0d passed, %0d failed of %0d", pass_cnt, fail_cnt, n_rows);
        if (fail_cnt == 0 && pass_cnt == n_rows)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/lab_pkg.sv
design/slow_clk_gen.sv
design/key_decoder.sv
design/bcd_counter.sv
design/seg7_scanner.sv
design/lab_top.sv
design/board_specific_top.sv
bench/board_sva.sv
bench/board_checker.sv
bench/tb_board.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the stopwatch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_board -f filelist.f

./obj_dir/Vtb_board | tee sim.log

if grep -qx "Regression passed" sim.log
then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
